// ==== common/qerv_isa_pkg.sv ====
`default_nettype none

package qerv_isa_pkg;

   // Major opcodes of the supported instructions
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // funct7 of sub, OP only
   localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

   typedef logic [4:0] reg_addr_t;

endpackage

`default_nettype wire

// ==== common/qerv_exec_pkg.sv ====
`default_nettype none

package qerv_exec_pkg;

   localparam int XLEN = 32;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_t;

   typedef enum logic [1:0] {
      FETCH,
      REQ,
      WAIT_RF,
      RUN
   } state_t;

   // Cycles in one serial pass over a register
   function automatic int chunks(input int w);
      return XLEN / w;
   endfunction

endpackage

`default_nettype wire

// ==== src/qerv_state.sv ====
`default_nettype none

module qerv_state (
   input  wire  clk,
   input  wire  i_rst,
   input  wire  i_ibus_ack,
   input  wire  i_rf_ready,
   input  wire  i_cnt_done,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_start
);

   qerv_exec_pkg::state_t state;

   // Counter starts with ready so the first chunk lines up with rdata
   assign o_cnt_start = (state == qerv_exec_pkg::WAIT_RF) && i_rf_ready;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state      <= qerv_exec_pkg::FETCH;
         o_ibus_cyc <= 1'b0;
         o_rf_rreq  <= 1'b0;
      end else begin
         o_rf_rreq <= 1'b0;
         case (state)
            qerv_exec_pkg::FETCH: begin
               // First fetch after reset
               if (!o_ibus_cyc) begin
                  o_ibus_cyc <= 1'b1;
               end else if (i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  o_rf_rreq  <= 1'b1;
                  state      <= qerv_exec_pkg::REQ;
               end
            end
            qerv_exec_pkg::REQ: begin
               state <= qerv_exec_pkg::WAIT_RF;
            end
            qerv_exec_pkg::WAIT_RF: begin
               if (i_rf_ready) begin
                  state <= qerv_exec_pkg::RUN;
               end
            end
            qerv_exec_pkg::RUN: begin
               // PC is complete in the next cycle
               if (i_cnt_done) begin
                  o_ibus_cyc <= 1'b1;
                  state      <= qerv_exec_pkg::FETCH;
               end
            end
            default: begin
               state <= qerv_exec_pkg::FETCH;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/qerv_counter.sv ====
`default_nettype none

module qerv_counter #(
   parameter int W = 4
) (
   input  wire  clk,
   input  wire  i_rst,
   input  wire  i_start,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done
);

   localparam int N  = qerv_exec_pkg::chunks(W);
   localparam int CW = (N > 1) ? $clog2(N) : 1;

   logic [CW-1:0] cnt;
   logic          last;

   assign last       = (cnt == CW'(N - 1));
   assign o_cnt0     = o_cnt_en && (cnt == '0);
   assign o_cnt_done = o_cnt_en && last;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_cnt_en <= 1'b0;
         cnt      <= '0;
      end else if (i_start) begin
         o_cnt_en <= 1'b1;
         cnt      <= '0;
      end else if (o_cnt_en) begin
         cnt <= cnt + 1'b1;
         // Idle after the last chunk
         if (last) begin
            o_cnt_en <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/qerv_decode.sv ====
`default_nettype none

module qerv_decode (
   input  wire                       clk,
   input  wire                       i_ibus_ack,
   input  wire  [31:0]               i_ibus_rdt,
   output qerv_exec_pkg::alu_op_t    o_alu_op,
   output logic                      o_use_imm,
   output logic                      o_rd_wen,
   output qerv_isa_pkg::reg_addr_t   o_rs1_addr,
   output qerv_isa_pkg::reg_addr_t   o_rs2_addr,
   output qerv_isa_pkg::reg_addr_t   o_rd_addr
);

   logic [31:0] insn;
   logic [6:0]  opcode;
   logic [6:0]  funct7;
   logic [2:0]  funct3;
   logic        is_op;
   logic        f7_zero;
   logic        valid;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         insn <= i_ibus_rdt;
      end
   end

   assign opcode     = insn[6:0];
   assign funct3     = insn[14:12];
   assign funct7     = insn[31:25];
   assign o_rd_addr  = insn[11:7];
   assign o_rs1_addr = insn[19:15];
   assign o_rs2_addr = insn[24:20];

   assign is_op     = (opcode == qerv_isa_pkg::OPC_OP);
   assign o_use_imm = (opcode == qerv_isa_pkg::OPC_OP_IMM);
   assign f7_zero   = (funct7 == 7'd0);

   always_comb begin
      o_alu_op = qerv_exec_pkg::ALU_ADD;
      valid    = 1'b0;
      case (funct3)
         qerv_isa_pkg::F3_ADD_SUB: begin
            valid = o_use_imm || (is_op && (f7_zero || funct7 == qerv_isa_pkg::FUNCT7_SUB));
            // addi has no sub form, funct7 there is immediate
            if (is_op && funct7 == qerv_isa_pkg::FUNCT7_SUB) begin
               o_alu_op = qerv_exec_pkg::ALU_SUB;
            end
         end
         qerv_isa_pkg::F3_XOR: begin
            valid    = o_use_imm || (is_op && f7_zero);
            o_alu_op = qerv_exec_pkg::ALU_XOR;
         end
         qerv_isa_pkg::F3_OR: begin
            valid    = o_use_imm || (is_op && f7_zero);
            o_alu_op = qerv_exec_pkg::ALU_OR;
         end
         qerv_isa_pkg::F3_AND: begin
            valid    = o_use_imm || (is_op && f7_zero);
            o_alu_op = qerv_exec_pkg::ALU_AND;
         end
         default: begin
            valid = 1'b0;
         end
      endcase
   end

   // Unsupported words and x0 writes become no-ops
   assign o_rd_wen = valid && (o_rd_addr != '0);

endmodule

`default_nettype wire

// ==== datapath/qerv_immdec.sv ====
`default_nettype none

module qerv_immdec #(
   parameter int W = 4
) (
   input  wire          clk,
   input  wire          i_ibus_ack,
   input  wire  [31:0]  i_ibus_rdt,
   input  wire          i_cnt_en,
   output logic [W-1:0] o_imm
);

   localparam int XLEN = qerv_exec_pkg::XLEN;

   logic [XLEN-1:0] imm;
   logic            sign;

   assign sign = imm[XLEN-1];

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         // I-type immediate, sign extended up front
         imm <= {{(XLEN - 12){i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
      end else if (i_cnt_en) begin
         // Arithmetic shift keeps the sign in the upper chunks
         imm <= XLEN'({{W{sign}}, imm} >> W);
      end
   end

   assign o_imm = imm[W-1:0];

endmodule

`default_nettype wire

// ==== datapath/qerv_alu.sv ====
`default_nettype none

module qerv_alu #(
   parameter int W = 4
) (
   input  wire                     clk,
   input  wire                     i_cnt_en,
   input  wire                     i_cnt0,
   input  qerv_exec_pkg::alu_op_t  i_alu_op,
   input  wire                     i_use_imm,
   input  wire  [W-1:0]            i_rs1,
   input  wire  [W-1:0]            i_rs2,
   input  wire  [W-1:0]            i_imm,
   output logic [W-1:0]            o_rd
);

   logic [W-1:0] op_b;
   logic [W-1:0] b_eff;
   logic         sub;
   logic         carry_in;
   logic         carry_r;
   logic [W:0]   sum;

   assign sub      = (i_alu_op == qerv_exec_pkg::ALU_SUB);
   assign op_b     = i_use_imm ? i_imm : i_rs2;
   assign b_eff    = sub ? ~op_b : op_b;
   // Two's complement: the +1 enters as carry on chunk 0
   assign carry_in = i_cnt0 ? sub : carry_r;
   assign sum      = {1'b0, i_rs1} + {1'b0, b_eff} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r <= sum[W];
      end
   end

   always_comb begin
      case (i_alu_op)
         qerv_exec_pkg::ALU_XOR: o_rd = i_rs1 ^ op_b;
         qerv_exec_pkg::ALU_OR:  o_rd = i_rs1 | op_b;
         qerv_exec_pkg::ALU_AND: o_rd = i_rs1 & op_b;
         default:                o_rd = sum[W-1:0];
      endcase
   end

endmodule

`default_nettype wire

// ==== datapath/qerv_ctrl.sv ====
`default_nettype none

module qerv_ctrl #(
   parameter int          W        = 4,
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  wire         clk,
   input  wire         i_rst,
   input  wire         i_cnt_en,
   input  wire         i_cnt0,
   output logic [31:0] o_ibus_adr
);

   localparam int           XLEN = qerv_exec_pkg::XLEN;
   localparam logic [W-1:0] INC  = W'(4);

   logic [XLEN-1:0] pc;
   logic [W-1:0]    addend;
   logic            carry_in;
   logic            carry_r;
   logic [W:0]      sum;

   // +4 only touches chunk 0, later chunks just ripple the carry
   assign addend   = i_cnt0 ? INC : '0;
   assign carry_in = !i_cnt0 && carry_r;
   assign sum      = {1'b0, pc[W-1:0]} + {1'b0, addend} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc <= RESET_PC;
      end else if (i_cnt_en) begin
         // Rotate right one chunk, new chunk enters at the top
         pc <= XLEN'({sum[W-1:0], pc} >> W);
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r <= sum[W];
      end
   end

   assign o_ibus_adr = pc;

endmodule

`default_nettype wire

// ==== src/qerv_top.sv ====
`default_nettype none

module qerv_top #(
   parameter int          W        = 4,
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  wire                            clk,
   input  wire                            i_rst,
   input  wire  [31:0]                    i_ibus_rdt,
   input  wire                            i_ibus_ack,
   input  wire                            i_rf_ready,
   input  wire  [W-1:0]                   i_rdata0,
   input  wire  [W-1:0]                   i_rdata1,
   output wire  [31:0]                    o_ibus_adr,
   output wire                            o_ibus_cyc,
   output wire                            o_rf_rreq,
   output wire  qerv_isa_pkg::reg_addr_t  o_rreg0,
   output wire  qerv_isa_pkg::reg_addr_t  o_rreg1,
   output wire  qerv_isa_pkg::reg_addr_t  o_wreg0,
   output wire                            o_wen0,
   output wire  [W-1:0]                   o_wdata0
);

   wire                          cnt_start;
   wire                          cnt_en;
   wire                          cnt0;
   wire                          cnt_done;
   wire qerv_exec_pkg::alu_op_t  alu_op;
   wire                          use_imm;
   wire                          rd_wen;
   wire [W-1:0]                  imm;

   // Only supported ops with rd != x0 reach the write port
   assign o_wen0 = cnt_en & rd_wen;

   qerv_state state (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_ibus_ack  (i_ibus_ack),
      .i_rf_ready  (i_rf_ready),
      .i_cnt_done  (cnt_done),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_rf_rreq   (o_rf_rreq),
      .o_cnt_start (cnt_start)
   );

   qerv_counter #(.W(W)) counter (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (cnt_start),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done)
   );

   qerv_decode decode (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_alu_op   (alu_op),
      .o_use_imm  (use_imm),
      .o_rd_wen   (rd_wen),
      .o_rs1_addr (o_rreg0),
      .o_rs2_addr (o_rreg1),
      .o_rd_addr  (o_wreg0)
   );

   qerv_immdec #(.W(W)) immdec (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .o_imm      (imm)
   );

   qerv_alu #(.W(W)) alu (
      .clk       (clk),
      .i_cnt_en  (cnt_en),
      .i_cnt0    (cnt0),
      .i_alu_op  (alu_op),
      .i_use_imm (use_imm),
      .i_rs1     (i_rdata0),
      .i_rs2     (i_rdata1),
      .i_imm     (imm),
      .o_rd      (o_wdata0)
   );

   qerv_ctrl #(.W(W), .RESET_PC(RESET_PC)) ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .o_ibus_adr (o_ibus_adr)
   );

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
`default_nettype none

module tb_checker #(
   parameter int          W        = 4,
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  wire          clk,
   input  wire          i_rst,
   input  wire          i_ibus_cyc,
   input  wire  [31:0]  i_ibus_adr,
   input  wire          i_ibus_ack,
   input  wire  [31:0]  i_ibus_rdt,
   input  wire          i_rf_rreq,
   input  wire  [4:0]   i_rreg0,
   input  wire  [4:0]   i_rreg1,
   input  wire          i_rf_ready,
   input  wire          i_wen0,
   input  wire  [4:0]   i_wreg0,
   input  wire  [W-1:0] i_wdata0,
   output int           o_value_errors,
   output int           o_other_errors
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_CHUNK = 32 / W;

   logic [31:0] model [32];
   logic [31:0] insn;
   logic [31:0] exp_pc;
   logic [31:0] exp_val;
   logic [31:0] got_val;
   logic [32:0] res;
   logic        exp_wen;
   logic        exp_cyc;
   logic        in_insn;
   int          pass_left;

   // Returns {supported, result} of one instruction word
   function automatic logic [32:0] reference_result(input logic [31:0] word,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
      logic [6:0]  opc;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [31:0] op_b;
      logic        reg_op;
      logic        is_sub;
      opc    = word[6:0];
      f3     = word[14:12];
      f7     = word[31:25];
      reg_op = (opc == qerv_isa_pkg::OPC_OP);
      is_sub = reg_op && (f7 == qerv_isa_pkg::FUNCT7_SUB) && (f3 == qerv_isa_pkg::F3_ADD_SUB);
      op_b   = reg_op ? b : {{20{word[31]}}, word[31:20]};
      if (!reg_op && opc != qerv_isa_pkg::OPC_OP_IMM) begin
         return {1'b0, 32'd0};
      end
      if (reg_op && f7 != 7'd0 && !is_sub) begin
         return {1'b0, 32'd0};
      end
      case (f3)
         qerv_isa_pkg::F3_ADD_SUB: return {1'b1, is_sub ? a - op_b : a + op_b};
         qerv_isa_pkg::F3_XOR:     return {1'b1, a ^ op_b};
         qerv_isa_pkg::F3_OR:      return {1'b1, a | op_b};
         qerv_isa_pkg::F3_AND:     return {1'b1, a & op_b};
         default:                  return {1'b0, 32'd0};
      endcase
   endfunction

   always @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < 32; i++) begin
            model[i] = tb_top.init_regs[i];
         end
         exp_pc         = RESET_PC;
         exp_wen        = 1'b0;
         exp_cyc        = 1'b0;
         in_insn        = 1'b0;
         insn           = '0;
         pass_left      = 0;
         o_value_errors = 0;
         o_other_errors = 0;
      end else begin
         if (i_ibus_cyc != exp_cyc) begin
            $display("MISMATCH at %0t: ibus cyc %b, expected %b",
                     $time, i_ibus_cyc, exp_cyc);
            o_value_errors++;
         end
         if (i_ibus_ack) begin
            if (i_ibus_adr != exp_pc) begin
               $display("MISMATCH at %0t: fetch address %h, expected %h",
                        $time, i_ibus_adr, exp_pc);
               o_value_errors++;
            end
            exp_pc  = exp_pc + 32'd4;
            insn    = i_ibus_rdt;
            in_insn = 1'b1;
            res     = reference_result(insn, model[insn[19:15]], model[insn[24:20]]);
            exp_wen = res[32] && (insn[11:7] != 5'd0);
            exp_val = res[31:0];
            if (exp_wen) begin
               model[insn[11:7]] = exp_val;
            end
         end
         if (i_rf_rreq && (i_rreg0 != insn[19:15] || i_rreg1 != insn[24:20])) begin
            $display("MISMATCH at %0t: read addresses x%0d x%0d, expected x%0d x%0d",
                     $time, i_rreg0, i_rreg1, insn[19:15], insn[24:20]);
            o_value_errors++;
         end
         if (pass_left > 0) begin
            if (i_wen0 != exp_wen) begin
               $display("MISMATCH at %0t: write enable %b, expected %b for insn %h",
                        $time, i_wen0, exp_wen, insn);
               o_value_errors++;
            end
            if (i_wen0 && i_wreg0 != insn[11:7]) begin
               $display("MISMATCH at %0t: write address x%0d, expected x%0d",
                        $time, i_wreg0, insn[11:7]);
               o_value_errors++;
            end
            got_val[(N_CHUNK - pass_left) * W +: W] = i_wdata0;
            pass_left--;
            if (pass_left == 0) begin
               in_insn = 1'b0;
            end
            if (pass_left == 0 && exp_wen && got_val != exp_val) begin
               $display("MISMATCH at %0t: insn %h wrote %h, expected %h",
                        $time, insn, got_val, exp_val);
               o_value_errors++;
            end
         end else if (i_wen0) begin
            $display("Write enable seen outside a register pass at %0t", $time);
            o_other_errors++;
         end
         // Pass starts in the cycle after ready
         if (i_rf_ready) begin
            pass_left = N_CHUNK;
         end
         // Fetch is idle from ack until the pass has ended
         exp_cyc = !in_insn;
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`default_nettype none

module tb_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          W        = 4;
   localparam logic [31:0] RESET_PC = 32'h0000_0100;
   localparam int          N_CHUNK  = 32 / W;
   localparam int          N_INSN   = 300;
   localparam int          RST_CYC  = 5;
   localparam int          TIMEOUT  = N_INSN * (N_CHUNK + 12) + RST_CYC;

   logic                     clk = 1'b0;
   logic                     rst;
   logic [31:0]              ibus_rdt;
   logic                     ibus_ack;
   logic                     rf_ready;
   logic [W-1:0]             rdata0;
   logic [W-1:0]             rdata1;
   wire  [31:0]              ibus_adr;
   wire                      ibus_cyc;
   wire                      rf_rreq;
   wire qerv_isa_pkg::reg_addr_t rreg0;
   wire qerv_isa_pkg::reg_addr_t rreg1;
   wire qerv_isa_pkg::reg_addr_t wreg0;
   wire                      wen0;
   wire  [W-1:0]             wdata0;

   logic [31:0] rng;
   logic [31:0] draw;
   logic [31:0] init_regs [32];
   logic [31:0] regs [32];
   logic [31:0] wr_val;
   logic [4:0]  raddr0;
   logic [4:0]  raddr1;
   int          ack_wait;
   int          ready_wait;
   int          serve_k;
   int          wr_k;
   int          insn_count;
   int          cycles = 0;
   int          value_errors;
   int          other_errors;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // r gives the fields, s picks the instruction class
   function automatic logic [31:0] build_insn(input logic [31:0] r, input logic [31:0] s);
      logic [2:0] f3_tab [4];
      logic [2:0] odd_f3 [4];
      logic [6:0] opc;
      logic [2:0] f3;
      logic [6:0] f7;
      int         kind;
      f3_tab = '{qerv_isa_pkg::F3_ADD_SUB, qerv_isa_pkg::F3_XOR,
                 qerv_isa_pkg::F3_OR, qerv_isa_pkg::F3_AND};
      odd_f3 = '{3'b001, 3'b010, 3'b011, 3'b101};
      kind   = int'(s[15:8] % 8'd9);
      opc    = r[6:0];
      f3     = r[14:12];
      f7     = r[31:25];
      if (s[31:24] < 8'd205) begin
         if (kind < 5) begin
            opc = qerv_isa_pkg::OPC_OP;
            f3  = f3_tab[kind % 4];
            f7  = (kind == 4) ? qerv_isa_pkg::FUNCT7_SUB : 7'd0;
         end else begin
            opc = qerv_isa_pkg::OPC_OP_IMM;
            f3  = f3_tab[kind - 5];
         end
      end else if (s[0]) begin
         // Shifts and slt
         opc = s[1] ? qerv_isa_pkg::OPC_OP : qerv_isa_pkg::OPC_OP_IMM;
         f3  = odd_f3[s[3:2]];
         f7  = 7'd0;
      end else if (opc == qerv_isa_pkg::OPC_OP || opc == qerv_isa_pkg::OPC_OP_IMM) begin
         // Turns into lui or auipc
         opc[2] = 1'b1;
      end
      return {f7, r[24:15], f3, r[11:7], opc};
   endfunction

   always #10 clk = ~clk;

   qerv_top #(.W(W), .RESET_PC(RESET_PC)) i_dut (
      .clk        (clk),
      .i_rst      (rst),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_rf_ready (rf_ready),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .o_rf_rreq  (rf_rreq),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .o_wreg0    (wreg0),
      .o_wen0     (wen0),
      .o_wdata0   (wdata0)
   );

   tb_checker #(.W(W), .RESET_PC(RESET_PC)) scoreboard (
      .clk            (clk),
      .i_rst          (rst),
      .i_ibus_cyc     (ibus_cyc),
      .i_ibus_adr     (ibus_adr),
      .i_ibus_ack     (ibus_ack),
      .i_ibus_rdt     (ibus_rdt),
      .i_rf_rreq      (rf_rreq),
      .i_rreg0        (rreg0),
      .i_rreg1        (rreg1),
      .i_rf_ready     (rf_ready),
      .i_wen0         (wen0),
      .i_wreg0        (wreg0),
      .i_wdata0       (wdata0),
      .o_value_errors (value_errors),
      .o_other_errors (other_errors)
   );

   // Instruction bus responder and register file model
   always @(posedge clk) begin
      ibus_ack <= 1'b0;
      rf_ready <= 1'b0;
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] = init_regs[i];
         end
         ack_wait   = -1;
         ready_wait = -1;
         serve_k    = -1;
         wr_k       = 0;
      end else begin
         if (ibus_cyc && !ibus_ack && insn_count < N_INSN) begin
            if (ack_wait < 0) begin
               rng      = xorshift32(rng);
               ack_wait = int'(rng % 32'd3);
            end
            if (ack_wait == 0) begin
               rng  = xorshift32(rng);
               draw = rng;
               rng  = xorshift32(rng);
               ibus_rdt <= build_insn(draw, rng);
               ibus_ack <= 1'b1;
               insn_count++;
            end
            ack_wait--;
         end
         if (rf_rreq) begin
            raddr0     = rreg0;
            raddr1     = rreg1;
            rng        = xorshift32(rng);
            ready_wait = int'(rng % 32'd3);
         end
         if (ready_wait == 0) begin
            rf_ready <= 1'b1;
         end
         if (ready_wait >= 0) begin
            ready_wait--;
         end
         if (rf_ready) begin
            serve_k = 0;
         end
         if (serve_k >= 0) begin
            rdata0 <= regs[raddr0][serve_k * W +: W];
            rdata1 <= regs[raddr1][serve_k * W +: W];
            serve_k = (serve_k == N_CHUNK - 1) ? -1 : serve_k + 1;
         end
         if (wen0) begin
            wr_val[wr_k * W +: W] = wdata0;
            wr_k++;
            if (wr_k == N_CHUNK) begin
               if (wreg0 != 5'd0) begin
                  regs[wreg0] = wr_val;
               end
               wr_k = 0;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      rng        = 32'd60292;
      rst        = 1'b1;
      ibus_rdt   = '0;
      ibus_ack   = 1'b0;
      rf_ready   = 1'b0;
      rdata0     = '0;
      rdata1     = '0;
      insn_count = 0;
      init_regs[0] = '0;
      for (int i = 1; i < 32; i++) begin
         rng          = xorshift32(rng);
         init_regs[i] = rng;
      end
      repeat (RST_CYC) @(posedge clk);
      rst <= 1'b0;
      // Last instruction is complete once the next fetch starts
      wait (insn_count == N_INSN);
      wait (!ibus_cyc);
      wait (ibus_cyc);
      repeat (2) @(posedge clk);
      $display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
common/qerv_isa_pkg.sv
common/qerv_exec_pkg.sv
src/qerv_state.sv
src/qerv_counter.sv
src/qerv_decode.sv
datapath/qerv_immdec.sv
datapath/qerv_alu.sv
datapath/qerv_ctrl.sv
src/qerv_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -qx "TEST PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
